// ==== vdiv.f ====
design/vdiv_pkg.sv
design/vdiv_operand_prep.sv
design/vdiv_radix4_step.sv
design/vdiv_element_sequencer.sv
design/vdiv_result_fixup.sv
design/vdiv.sv
tests/vdiv_checker.sv
tests/vdiv_tb.sv

// ==== Makefile ====
# Verilator build and run for the vdiv divider testbench

TOOL       := verilator
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only -Wall --timing
TOP        := vdiv_tb
RTL_TOP    := vdiv
FILELIST   := vdiv.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed
FAIL_MSG   := Checks failed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the outcome, a missing pass line also counts as a failure
run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@echo "simulation passed"

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tests/vdiv_tb.sv ====
// vdiv testbench driving table and random divides and checking each lane against a reference model
`timescale 1ns/100ps

module vdiv_tb;
  import vdiv_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          DRIVE_DELAY  = 2;
  localparam int          RESULT_EDGES = 32;
  localparam int          IDLE_EDGES   = 3;
  localparam int          NUM_RANDOM   = 24;
  localparam int          EDGES_PER_OP = 36;
  localparam logic [31:0] SEED         = 32'h30db_eb46;

  logic        clk_i;
  logic        rstn_i;
  logic        instr_valid_i;
  div_op_e     op_i;
  sew_e        sew_i;
  logic [63:0] data_vs1_i;
  logic [63:0] data_vs2_i;
  logic [63:0] data_vd_o;

  div_op_e     tbl_op[$];
  sew_e        tbl_sew[$];
  logic [63:0] tbl_vs1[$];
  logic [63:0] tbl_vs2[$];
  logic [63:0] tbl_exp[$];
  int          cycle_cnt;
  int          cycle_limit;

  vdiv vdiv_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .sew_i         (sew_i),
    .data_vs1_i    (data_vs1_i),
    .data_vs2_i    (data_vs2_i),
    .data_vd_o     (data_vd_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Checks failed");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  // RISC-V rules per element: truncating signed division, remainder takes the
  // dividend's sign, x/0 gives all ones and x, and min/-1 gives min with remainder 0
  function automatic logic [63:0] ref_result(input div_op_e op, input sew_e sew,
                                             input logic [63:0] vs1, input logic [63:0] vs2);
    int          w;
    logic [63:0] mask;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] q;
    logic [63:0] r;
    logic [63:0] res;
    longint      sa;
    longint      sb;
    logic        sgn;
    logic        want_rem;
    w = (sew == SEW_8) ? 8 : (sew == SEW_16) ? 16 : (sew == SEW_32) ? 32 : 64;
    mask = (w == 64) ? '1 : ((64'd1 << w) - 64'd1);
    sgn = (op == OP_DIV) || (op == OP_REM);
    want_rem = (op == OP_REM) || (op == OP_REMU);
    res = '0;
    for (int lane = 0; lane < 64 / w; lane++) begin
      a = (vs2 >> (lane * w)) & mask;
      b = (vs1 >> (lane * w)) & mask;
      sa = longint'(a << (64 - w)) >>> (64 - w);
      sb = longint'(b << (64 - w)) >>> (64 - w);
      if (b == '0) begin
        q = '1;
        r = a;
      end else if (sgn && a == (64'd1 << (w - 1)) && b == mask) begin
        q = a;
        r = '0;
      end else if (sgn) begin
        q = sa / sb;
        r = sa % sb;
      end else begin
        q = a / b;
        r = a % b;
      end
      res = res | (((want_rem ? r : q) & mask) << (lane * w));
    end
    return res;
  endfunction

  task automatic add_entry(input div_op_e op, input sew_e sew, input logic [63:0] vs1,
                           input logic [63:0] vs2);
    tbl_op.push_back(op);
    tbl_sew.push_back(sew);
    tbl_vs1.push_back(vs1);
    tbl_vs2.push_back(vs2);
    tbl_exp.push_back(ref_result(op, sew, vs1, vs2));
  endtask

  task automatic build_table();
    // unsigned on every element width
    add_entry(OP_DIVU, SEW_8,  64'h0103_0507_0911_ff02, 64'hff64_3c80_7f20_0a09);
    add_entry(OP_REMU, SEW_8,  64'h0103_0507_0911_ff02, 64'hff64_3c80_7f20_0a09);
    add_entry(OP_DIVU, SEW_16, 64'h0007_1234_00ff_fffe, 64'hffff_abcd_8000_1234);
    add_entry(OP_REMU, SEW_16, 64'h0007_1234_00ff_fffe, 64'hffff_abcd_8000_1234);
    add_entry(OP_DIVU, SEW_32, 64'h0000_0003_1234_5678, 64'hffff_ffff_8765_4321);
    add_entry(OP_REMU, SEW_32, 64'h0000_0003_1234_5678, 64'hffff_ffff_8765_4321);
    add_entry(OP_DIVU, SEW_64, 64'h0000_0000_0001_2345, 64'hfedc_ba98_7654_3210);
    add_entry(OP_REMU, SEW_64, 64'h0000_0000_0001_2345, 64'hfedc_ba98_7654_3210);
    // signed with mixed operand signs
    add_entry(OP_DIV,  SEW_8,  64'hfd03_fd03_f907_02fe, 64'h07f9_f907_649c_9c64);
    add_entry(OP_REM,  SEW_8,  64'hfd03_fd03_f907_02fe, 64'h07f9_f907_649c_9c64);
    add_entry(OP_DIV,  SEW_16, 64'hfff9_0007_fff9_0003, 64'h8001_8001_7fff_c000);
    add_entry(OP_REM,  SEW_16, 64'hfff9_0007_fff9_0003, 64'h8001_8001_7fff_c000);
    add_entry(OP_DIV,  SEW_32, 64'hffff_fffd_0000_0007, 64'h8000_0001_ffff_ff9c);
    add_entry(OP_REM,  SEW_32, 64'hffff_fffd_0000_0007, 64'h8000_0001_ffff_ff9c);
    add_entry(OP_DIV,  SEW_64, 64'hffff_ffff_ffff_fff9, 64'h8000_0000_0000_0064);
    add_entry(OP_REM,  SEW_64, 64'h0000_0000_0000_0007, 64'hffff_ffff_ffff_ff9b);
    // zero divisors in some lanes only
    add_entry(OP_DIVU, SEW_8,  64'h0003_0000_0500_0700, 64'h1122_3344_5566_7788);
    add_entry(OP_REM,  SEW_8,  64'h0003_0000_0500_0700, 64'h80f0_9c64_ff01_7f80);
    add_entry(OP_DIV,  SEW_16, 64'h0000_fffd_0000_0005, 64'h8000_7000_fff6_fff6);
    add_entry(OP_REMU, SEW_32, 64'h0000_0000_0000_0005, 64'hffff_fff6_ffff_fff6);
    // most negative value over minus one
    add_entry(OP_DIV,  SEW_8,  64'hffff_ffff_ffff_ffff, 64'h8080_8080_8080_8080);
    add_entry(OP_REM,  SEW_16, 64'hffff_ffff_ffff_ffff, 64'h8000_8000_8000_8000);
    add_entry(OP_DIV,  SEW_32, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_8000_0000);
    add_entry(OP_DIV,  SEW_64, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
    add_entry(OP_REM,  SEW_64, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      add_entry(div_op_e'(2'($urandom_range(3, 0))), sew_e'(2'($urandom_range(3, 0))),
                {$urandom, $urandom}, {$urandom, $urandom});
    end
  endtask

  // ------------------------------
  // drive and check helpers
  // ------------------------------
  task automatic wait_edges(input int n);
    repeat (n) @(posedge clk_i);
    #DRIVE_DELAY;
  endtask

  // the strobe is seen at the next rising edge, which is the acceptance edge
  task automatic issue_instr(input div_op_e op, input sew_e sew, input logic [63:0] vs1,
                             input logic [63:0] vs2);
    op_i          = op;
    sew_i         = sew;
    data_vs1_i    = vs1;
    data_vs2_i    = vs2;
    instr_valid_i = 1'b1;
    wait_edges(1);
    instr_valid_i = 1'b0;
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  initial begin
    rstn_i        = 1'b0;
    instr_valid_i = 1'b0;
    op_i          = OP_DIVU;
    sew_i         = SEW_8;
    data_vs1_i    = '0;
    data_vs2_i    = '0;
    cycle_cnt     = 0;
    void'($urandom(SEED));
    build_table();
    // two extra slots cover the reset check and the restart case
    cycle_limit = (tbl_op.size() + 2) * EDGES_PER_OP + 100;

    wait_edges(2);
    rstn_i = 1'b1;
    wait_edges(1);
    check_value(data_vd_o, 64'd0, "result after reset");

    for (int i = 0; i < tbl_op.size(); i++) begin
      issue_instr(tbl_op[i], tbl_sew[i], tbl_vs1[i], tbl_vs2[i]);
      wait_edges(RESULT_EDGES);
      check_value(data_vd_o, tbl_exp[i], $sformatf("entry %0d", i));
      // a few idle cycles keep the final result on the port before the next divide
      wait_edges(IDLE_EDGES);
    end

    // a second divide lands ten cycles into the first and replaces it
    issue_instr(OP_DIVU, SEW_16, 64'h0003_0005_0007_0009, 64'hffff_ffff_ffff_ffff);
    wait_edges(9);
    issue_instr(OP_REM, SEW_32, 64'h0000_0007_ffff_fffd, 64'hffff_ff9c_0000_0064);
    wait_edges(RESULT_EDGES);
    check_value(data_vd_o,
                ref_result(OP_REM, SEW_32, 64'h0000_0007_ffff_fffd, 64'hffff_ff9c_0000_0064),
                "restarted divide");
    wait_edges(IDLE_EDGES);

    if (vdiv_inst.checker_inst.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== tests/vdiv_checker.sv ====
// vdiv checker with concurrent assertions on the result port of the divider
`timescale 1ns/100ps

module vdiv_checker (
  input logic                        clk_i,
  input logic                        rstn_i,
  input logic                        instr_valid_i,
  input logic [vdiv_pkg::DATA_W-1:0] data_vd_i
);
  import vdiv_pkg::*;

  // the last lane is captured at edge 32, the word is settled from edge 33 on
  localparam int SETTLED = DIV_LATENCY + 1;

  logic       accepted_q;
  logic [6:0] since_accept_q;

  // number of failed assertions over the run
  int         fail_cnt = 0;

  // counts edges since the last acceptance and saturates
  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      accepted_q     <= 1'b0;
      since_accept_q <= '0;
    end else if (instr_valid_i) begin
      accepted_q     <= 1'b1;
      since_accept_q <= '0;
    end else if (since_accept_q != '1) begin
      since_accept_q <= since_accept_q + 7'd1;
    end
  end

  a_no_unknown: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !$isunknown(data_vd_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("result word has unknown bits");
    end

  a_zero_before_first: assert property (@(posedge clk_i) disable iff (!rstn_i)
    !accepted_q |-> data_vd_i == '0)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("result word is not zero before the first instruction");
    end

  a_result_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
    (accepted_q && since_accept_q >= 7'(SETTLED)) |-> $stable(data_vd_i))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("final result changed before the next instruction");
    end

endmodule

bind vdiv vdiv_checker checker_inst (
  .clk_i         (clk_i),
  .rstn_i        (rstn_i),
  .instr_valid_i (instr_valid_i),
  .data_vd_i     (data_vd_o)
);

// ==== design/vdiv.sv ====
// vdiv top: iterative SIMD integer divider for 8, 16, 32 and 64-bit elements of a 64-bit word
`timescale 1ns/100ps

module vdiv (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  instr_valid_i,
  input  vdiv_pkg::div_op_e     op_i,
  input  vdiv_pkg::sew_e        sew_i,
  input  vdiv_pkg::vdiv_word_u  data_vs1_i,
  input  vdiv_pkg::vdiv_word_u  data_vs2_i,
  output vdiv_pkg::vdiv_word_u  data_vd_o
);
  import vdiv_pkg::*;

  vdiv_word_u           mag_vs1_d;
  vdiv_word_u           mag_vs2_d;
  vdiv_word_u           mag_vs1_q;
  vdiv_word_u           mag_vs2_q;
  vdiv_word_u           dividend_q;
  logic [MAX_LANES-1:0] neg_result;
  logic [MAX_LANES-1:0] div_zero;
  div_op_e              op_q;
  sew_e                 sew_q;
  vdiv_word_u           raw_quot;
  vdiv_word_u           raw_rem;

  vdiv_operand_prep prep_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .sew_i         (sew_i),
    .data_vs1_i    (data_vs1_i),
    .data_vs2_i    (data_vs2_i),
    .mag_vs1_d_o   (mag_vs1_d),
    .mag_vs2_d_o   (mag_vs2_d),
    .mag_vs1_o     (mag_vs1_q),
    .mag_vs2_o     (mag_vs2_q),
    .dividend_o    (dividend_q),
    .neg_result_o  (neg_result),
    .div_zero_o    (div_zero),
    .op_o          (op_q),
    .sew_o         (sew_q)
  );

  // the highest lane is loaded on the acceptance edge from the unregistered magnitudes
  vdiv_element_sequencer seq_inst (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .instr_valid_i (instr_valid_i),
    .sew_i         (sew_i),
    .sew_q_i       (sew_q),
    .mag_vs1_d_i   (mag_vs1_d),
    .mag_vs2_d_i   (mag_vs2_d),
    .mag_vs1_i     (mag_vs1_q),
    .mag_vs2_i     (mag_vs2_q),
    .raw_quot_o    (raw_quot),
    .raw_rem_o     (raw_rem)
  );

  vdiv_result_fixup fixup_inst (
    .op_i          (op_q),
    .sew_i         (sew_q),
    .dividend_i    (dividend_q),
    .raw_quot_i    (raw_quot),
    .raw_rem_i     (raw_rem),
    .neg_result_i  (neg_result),
    .div_zero_i    (div_zero),
    .data_vd_o     (data_vd_o)
  );

endmodule

// ==== design/vdiv_result_fixup.sv ====
// vdiv result fixup: restores signs, applies divide-by-zero values and selects quotient or remainder
`timescale 1ns/100ps

module vdiv_result_fixup (
  input  vdiv_pkg::div_op_e              op_i,
  input  vdiv_pkg::sew_e                 sew_i,
  input  vdiv_pkg::vdiv_word_u           dividend_i,
  input  vdiv_pkg::vdiv_word_u           raw_quot_i,
  input  vdiv_pkg::vdiv_word_u           raw_rem_i,
  input  logic [vdiv_pkg::MAX_LANES-1:0] neg_result_i,
  input  logic [vdiv_pkg::MAX_LANES-1:0] div_zero_i,
  output vdiv_pkg::vdiv_word_u           data_vd_o
);
  import vdiv_pkg::*;

  logic       signed_op;
  vdiv_word_u quot_w;
  vdiv_word_u rem_w;

  // lanes are widened to 64 bits here and cut back on assignment,
  // which keeps the negation and the all-ones value correct per width
  function automatic logic [DATA_W-1:0] fix_quot(input logic [DATA_W-1:0] raw,
                                                 input logic zero, input logic neg);
    if (zero) return '1;
    return neg ? -raw : raw;
  endfunction

  function automatic logic [DATA_W-1:0] fix_rem(input logic [DATA_W-1:0] raw,
                                                input logic [DATA_W-1:0] dividend,
                                                input logic zero, input logic neg);
    if (zero) return dividend;
    return neg ? -raw : raw;
  endfunction

  assign signed_op = is_signed_op(op_i);

  // neg_result is only ever set for signed ops, the remainder follows the dividend sign
  always_comb begin
    quot_w = '0;
    rem_w  = '0;
    case (sew_i)
      SEW_8: begin
        for (int i = 0; i < MAX_LANES; i++) begin
          quot_w.e8[i] = 8'(fix_quot(DATA_W'(raw_quot_i.e8[i]), div_zero_i[i], neg_result_i[i]));
          rem_w.e8[i]  = 8'(fix_rem(DATA_W'(raw_rem_i.e8[i]), DATA_W'(dividend_i.e8[i]),
                                    div_zero_i[i], signed_op && dividend_i.e8[i][7]));
        end
      end
      SEW_16: begin
        for (int i = 0; i < MAX_LANES / 2; i++) begin
          quot_w.e16[i] = 16'(fix_quot(DATA_W'(raw_quot_i.e16[i]), div_zero_i[i],
                                       neg_result_i[i]));
          rem_w.e16[i]  = 16'(fix_rem(DATA_W'(raw_rem_i.e16[i]), DATA_W'(dividend_i.e16[i]),
                                      div_zero_i[i], signed_op && dividend_i.e16[i][15]));
        end
      end
      SEW_32: begin
        for (int i = 0; i < MAX_LANES / 4; i++) begin
          quot_w.e32[i] = 32'(fix_quot(DATA_W'(raw_quot_i.e32[i]), div_zero_i[i],
                                       neg_result_i[i]));
          rem_w.e32[i]  = 32'(fix_rem(DATA_W'(raw_rem_i.e32[i]), DATA_W'(dividend_i.e32[i]),
                                      div_zero_i[i], signed_op && dividend_i.e32[i][31]));
        end
      end
      default: begin
        quot_w.e64 = fix_quot(raw_quot_i.e64, div_zero_i[0], neg_result_i[0]);
        rem_w.e64  = fix_rem(raw_rem_i.e64, dividend_i.e64, div_zero_i[0],
                             signed_op && dividend_i.e64[63]);
      end
    endcase
  end

  assign data_vd_o = is_rem_op(op_i) ? rem_w : quot_w;

endmodule

// ==== design/vdiv_element_sequencer.sv ====
// vdiv element sequencer: runs the shared step over each lane, highest first, and collects results
`timescale 1ns/100ps

module vdiv_element_sequencer (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  logic                  instr_valid_i,
  input  vdiv_pkg::sew_e        sew_i,
  input  vdiv_pkg::sew_e        sew_q_i,
  input  vdiv_pkg::vdiv_word_u  mag_vs1_d_i,
  input  vdiv_pkg::vdiv_word_u  mag_vs2_d_i,
  input  vdiv_pkg::vdiv_word_u  mag_vs1_i,
  input  vdiv_pkg::vdiv_word_u  mag_vs2_i,
  output vdiv_pkg::vdiv_word_u  raw_quot_o,
  output vdiv_pkg::vdiv_word_u  raw_rem_o
);
  import vdiv_pkg::*;

  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] quot_q;
  logic [DATA_W-1:0] divisor_q;
  logic [DATA_W-1:0] step_rem;
  logic [DATA_W-1:0] step_quot;
  logic [5:0]        step_cnt_q;
  logic [3:0]        lane_cnt_q;
  logic              busy_q;

  logic [5:0]        first_steps;
  logic [5:0]        next_steps;
  logic [3:0]        first_lane;
  logic [2:0]        next_lane;

  // pick one element out of a word, zero-extended to the datapath width
  function automatic logic [DATA_W-1:0] lane_of(input vdiv_word_u w, input sew_e sew,
                                                input logic [2:0] idx);
    case (sew)
      SEW_8:   return DATA_W'(w.e8[idx]);
      SEW_16:  return DATA_W'(w.e16[idx[1:0]]);
      SEW_32:  return DATA_W'(w.e32[idx[0]]);
      default: return w.e64;
    endcase
  endfunction

  assign first_steps = steps_of(sew_i) - 6'd1;
  assign next_steps  = steps_of(sew_q_i) - 6'd1;
  assign first_lane  = lanes_of(sew_i) - 4'd1;
  assign next_lane   = lane_cnt_q[2:0] - 3'd1;

  vdiv_radix4_step step_inst (
    .sew_i     (sew_q_i),
    .rem_i     (rem_q),
    .quot_i    (quot_q),
    .divisor_i (divisor_q),
    .rem_o     (step_rem),
    .quot_o    (step_quot)
  );

  // ------------------------------
  // step and lane control
  // ------------------------------
  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      rem_q      <= '0;
      quot_q     <= '0;
      divisor_q  <= '0;
      step_cnt_q <= '0;
      lane_cnt_q <= '0;
      busy_q     <= 1'b0;
      raw_quot_o <= '0;
      raw_rem_o  <= '0;
    end else if (instr_valid_i) begin
      // a new instruction restarts at its highest lane, straight from the inputs
      rem_q      <= '0;
      quot_q     <= lane_of(mag_vs2_d_i, sew_i, first_lane[2:0]);
      divisor_q  <= lane_of(mag_vs1_d_i, sew_i, first_lane[2:0]);
      step_cnt_q <= first_steps;
      lane_cnt_q <= first_lane;
      busy_q     <= 1'b1;
    end else if (busy_q) begin
      if (step_cnt_q != '0) begin
        rem_q      <= step_rem;
        quot_q     <= step_quot;
        step_cnt_q <= step_cnt_q - 6'd1;
      end else begin
        // the last step of this element is stored without passing through the registers
        case (sew_q_i)
          SEW_8: begin
            raw_quot_o.e8[lane_cnt_q[2:0]] <= step_quot[7:0];
            raw_rem_o.e8[lane_cnt_q[2:0]]  <= step_rem[7:0];
          end
          SEW_16: begin
            raw_quot_o.e16[lane_cnt_q[1:0]] <= step_quot[15:0];
            raw_rem_o.e16[lane_cnt_q[1:0]]  <= step_rem[15:0];
          end
          SEW_32: begin
            raw_quot_o.e32[lane_cnt_q[0]] <= step_quot[31:0];
            raw_rem_o.e32[lane_cnt_q[0]]  <= step_rem[31:0];
          end
          default: begin
            raw_quot_o.e64 <= step_quot;
            raw_rem_o.e64  <= step_rem;
          end
        endcase
        if (lane_cnt_q != '0) begin
          rem_q      <= '0;
          quot_q     <= lane_of(mag_vs2_i, sew_q_i, next_lane);
          divisor_q  <= lane_of(mag_vs1_i, sew_q_i, next_lane);
          step_cnt_q <= next_steps;
          lane_cnt_q <= lane_cnt_q - 4'd1;
        end else begin
          busy_q <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== design/vdiv_radix4_step.sv ====
// vdiv radix-4 step: two restoring shift-and-subtract iterations on one element per call
`timescale 1ns/100ps

module vdiv_radix4_step (
  input  vdiv_pkg::sew_e               sew_i,
  input  logic [vdiv_pkg::DATA_W-1:0]  rem_i,
  input  logic [vdiv_pkg::DATA_W-1:0]  quot_i,
  input  logic [vdiv_pkg::DATA_W-1:0]  divisor_i,
  output logic [vdiv_pkg::DATA_W-1:0]  rem_o,
  output logic [vdiv_pkg::DATA_W-1:0]  quot_o
);
  import vdiv_pkg::*;

  // the partial remainder needs one extra bit right after the shift
  logic [DATA_W:0]   rem_w;
  logic [DATA_W-1:0] quot_w;
  logic [DATA_W-1:0] field_mask;
  logic [5:0]        msb;

  // the element sits zero-extended in the low SEW bits
  always_comb begin
    case (sew_i)
      SEW_8: begin
        field_mask = 64'h0000_0000_0000_00ff;
        msb        = 6'd7;
      end
      SEW_16: begin
        field_mask = 64'h0000_0000_0000_ffff;
        msb        = 6'd15;
      end
      SEW_32: begin
        field_mask = 64'h0000_0000_ffff_ffff;
        msb        = 6'd31;
      end
      default: begin
        field_mask = '1;
        msb        = 6'd63;
      end
    endcase
  end

  // dividend bits leave at the top of the field while quotient bits enter at the bottom
  always_comb begin
    rem_w  = {1'b0, rem_i};
    quot_w = quot_i;
    for (int k = 0; k < BITS_PER_STEP; k++) begin
      rem_w  = {rem_w[DATA_W-1:0], quot_w[msb]};
      quot_w = (quot_w << 1) & field_mask;
      if (rem_w >= {1'b0, divisor_i}) begin
        rem_w     = rem_w - {1'b0, divisor_i};
        quot_w[0] = 1'b1;
      end
    end
    rem_o  = rem_w[DATA_W-1:0];
    quot_o = quot_w;
  end

endmodule

// ==== design/vdiv_operand_prep.sv ====
// vdiv operand prep: per-lane magnitudes, quotient signs and zero-divisor flags, held per instruction
`timescale 1ns/100ps

module vdiv_operand_prep (
  input  logic                   clk_i,
  input  logic                   rstn_i,
  input  logic                   instr_valid_i,
  input  vdiv_pkg::div_op_e      op_i,
  input  vdiv_pkg::sew_e         sew_i,
  input  vdiv_pkg::vdiv_word_u   data_vs1_i,
  input  vdiv_pkg::vdiv_word_u   data_vs2_i,
  output vdiv_pkg::vdiv_word_u   mag_vs1_d_o,
  output vdiv_pkg::vdiv_word_u   mag_vs2_d_o,
  output vdiv_pkg::vdiv_word_u   mag_vs1_o,
  output vdiv_pkg::vdiv_word_u   mag_vs2_o,
  output vdiv_pkg::vdiv_word_u   dividend_o,
  output logic [vdiv_pkg::MAX_LANES-1:0] neg_result_o,
  output logic [vdiv_pkg::MAX_LANES-1:0] div_zero_o,
  output vdiv_pkg::div_op_e      op_o,
  output vdiv_pkg::sew_e         sew_o
);
  import vdiv_pkg::*;

  logic                 signed_op;
  logic [MAX_LANES-1:0] neg_d;
  logic [MAX_LANES-1:0] zero_d;

  assign signed_op = is_signed_op(op_i);

  // magnitudes are taken from the incoming operands every cycle, the
  // sequencer only looks at them on the acceptance edge
  always_comb begin
    mag_vs1_d_o = '0;
    mag_vs2_d_o = '0;
    neg_d       = '0;
    zero_d      = '0;
    case (sew_i)
      SEW_8: begin
        for (int i = 0; i < MAX_LANES; i++) begin
          neg_d[i]  = signed_op & (data_vs1_i.e8[i][7] ^ data_vs2_i.e8[i][7]);
          zero_d[i] = (data_vs1_i.e8[i] == '0);
          mag_vs1_d_o.e8[i] = (signed_op && data_vs1_i.e8[i][7]) ?
                              -data_vs1_i.e8[i] : data_vs1_i.e8[i];
          mag_vs2_d_o.e8[i] = (signed_op && data_vs2_i.e8[i][7]) ?
                              -data_vs2_i.e8[i] : data_vs2_i.e8[i];
        end
      end
      SEW_16: begin
        for (int i = 0; i < MAX_LANES / 2; i++) begin
          neg_d[i]  = signed_op & (data_vs1_i.e16[i][15] ^ data_vs2_i.e16[i][15]);
          zero_d[i] = (data_vs1_i.e16[i] == '0);
          mag_vs1_d_o.e16[i] = (signed_op && data_vs1_i.e16[i][15]) ?
                               -data_vs1_i.e16[i] : data_vs1_i.e16[i];
          mag_vs2_d_o.e16[i] = (signed_op && data_vs2_i.e16[i][15]) ?
                               -data_vs2_i.e16[i] : data_vs2_i.e16[i];
        end
      end
      SEW_32: begin
        for (int i = 0; i < MAX_LANES / 4; i++) begin
          neg_d[i]  = signed_op & (data_vs1_i.e32[i][31] ^ data_vs2_i.e32[i][31]);
          zero_d[i] = (data_vs1_i.e32[i] == '0);
          mag_vs1_d_o.e32[i] = (signed_op && data_vs1_i.e32[i][31]) ?
                               -data_vs1_i.e32[i] : data_vs1_i.e32[i];
          mag_vs2_d_o.e32[i] = (signed_op && data_vs2_i.e32[i][31]) ?
                               -data_vs2_i.e32[i] : data_vs2_i.e32[i];
        end
      end
      default: begin
        neg_d[0]  = signed_op & (data_vs1_i.e64[63] ^ data_vs2_i.e64[63]);
        zero_d[0] = (data_vs1_i.e64 == '0);
        mag_vs1_d_o.e64 = (signed_op && data_vs1_i.e64[63]) ? -data_vs1_i.e64 : data_vs1_i.e64;
        mag_vs2_d_o.e64 = (signed_op && data_vs2_i.e64[63]) ? -data_vs2_i.e64 : data_vs2_i.e64;
      end
    endcase
  end

  // ------------------------------
  // held until the next acceptance
  // ------------------------------
  always_ff @(posedge clk_i, negedge rstn_i) begin
    if (!rstn_i) begin
      mag_vs1_o    <= '0;
      mag_vs2_o    <= '0;
      dividend_o   <= '0;
      neg_result_o <= '0;
      div_zero_o   <= '0;
      op_o         <= OP_DIVU;
      sew_o        <= SEW_8;
    end else if (instr_valid_i) begin
      mag_vs1_o    <= mag_vs1_d_o;
      mag_vs2_o    <= mag_vs2_d_o;
      dividend_o   <= data_vs2_i;
      neg_result_o <= neg_d;
      div_zero_o   <= zero_d;
      op_o         <= op_i;
      sew_o        <= sew_i;
    end
  end

endmodule

// ==== design/vdiv_pkg.sv ====
// vdiv shared definitions: divide opcodes, element widths, the lane word and divider constants
package vdiv_pkg;

  // ------------------------------
  // divider constants
  // ------------------------------
  localparam int DATA_W        = 64;
  localparam int MAX_LANES     = 8;
  localparam int BITS_PER_STEP = 2;
  // lanes times SEW/2 is 32 for every element width
  localparam int DIV_LATENCY   = 32;

  // unsigned ops are even, the signed variant sets bit 0
  typedef enum logic [1:0] {
    OP_DIVU = 2'b00,
    OP_DIV  = 2'b01,
    OP_REMU = 2'b10,
    OP_REM  = 2'b11
  } div_op_e;

  typedef enum logic [1:0] {
    SEW_8  = 2'b00,
    SEW_16 = 2'b01,
    SEW_32 = 2'b10,
    SEW_64 = 2'b11
  } sew_e;

  // one 64-bit vector word seen through each element width
  typedef union packed {
    logic [7:0][7:0]  e8;
    logic [3:0][15:0] e16;
    logic [1:0][31:0] e32;
    logic [63:0]      e64;
  } vdiv_word_u;

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic is_signed_op(input div_op_e op);
    return (op == OP_DIV) || (op == OP_REM);
  endfunction

  function automatic logic is_rem_op(input div_op_e op);
    return (op == OP_REM) || (op == OP_REMU);
  endfunction

  // number of elements packed in one word
  function automatic logic [3:0] lanes_of(input sew_e sew);
    case (sew)
      SEW_8:   return 4'd8;
      SEW_16:  return 4'd4;
      SEW_32:  return 4'd2;
      default: return 4'd1;
    endcase
  endfunction

  // cycles spent on one element at two quotient bits per cycle
  function automatic logic [5:0] steps_of(input sew_e sew);
    case (sew)
      SEW_8:   return 6'd4;
      SEW_16:  return 6'd8;
      SEW_32:  return 6'd16;
      default: return 6'd32;
    endcase
  endfunction

endpackage
